// File: list.f
src/cpuPkg.sv
src/stageIf.sv
src/fetchStage.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipeCpu.sv
verif/tbClock.sv
verif/pipeCpuTb.sv

// File: Bender.yml
package:
  name: pipeCpu

sources:
  - files:
      - src/cpuPkg.sv
      - src/stageIf.sv
      - src/fetchStage.sv
      - src/regFile.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/pipeCpu.sv
  - target: test
    files:
      - verif/tbClock.sv
      - verif/pipeCpuTb.sv

// File: verif/pipeCpuTb.sv
//********************
// Testbench for the pipelined processor with memory models,
// an ISA-level reference and directed tests
//********************
`timescale 1ns/1ps

module pipeCpuTb import cpuPkg::*; ();

   localparam dataWord_t RESET_PC = 16'h0000;
   localparam int TEST_LIMIT = 200;
   // Six tests of at most 200 cycles each, plus resets and margin
   localparam int CYCLE_LIMIT = 1500;

   logic      clk, rstN, resetReq;
   dataWord_t imemAddr, imemData, dmemAddr, dmemWrData, dmemRdData;
   logic      dmemWrEn, dmemRdEn, halted, err;

   dataWord_t imem [256];
   dataWord_t dmem [256];
   dataWord_t gotAddr[$], gotData[$], expAddr[$], expData[$];
   int        errorCount, checkCount, testCount, loadPtr;
   int        cycleCount = 0;

   tbClock u_tbClock (.resetReq(resetReq), .clk(clk), .rstN(rstN));

   pipeCpu #(.RESET_PC(RESET_PC)) u_pipeCpu (
      .clk(clk), .rstN(rstN),
      .imemAddr(imemAddr), .imemData(imemData),
      .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
      .dmemWrEn(dmemWrEn), .dmemRdEn(dmemRdEn), .dmemRdData(dmemRdData),
      .halted(halted), .err(err)
   );

   assign imemData   = imem[imemAddr[7:0]];
   // Read data only while a load asks for it
   assign dmemRdData = dmemRdEn ? dmem[dmemAddr[7:0]] : 'x;

   // Store log and data memory write, sampled mid-cycle
   always @(negedge clk) begin
      if (rstN && dmemWrEn) begin
         gotAddr.push_back(dmemAddr);
         gotData.push_back(dmemWrData);
         dmem[dmemAddr[7:0]] = dmemWrData;
      end
   end

   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles before all tests finished", cycleCount);
         $display("Errors found");
         $finish;
      end
   end

   task automatic checkWord(input string what, input dataWord_t got, input dataWord_t exp);
      checkCount++;
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkFlag(input string what, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
         errorCount++;
      end
   endtask

   function automatic dataWord_t encodeR(opcode_e op, regIdx_t rd, regIdx_t rs, regIdx_t rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic dataWord_t encodeI(opcode_e op, regIdx_t rd, regIdx_t rs, int imm);
      return {op, rd, rs, imm[5:0]};
   endfunction

   function automatic opcode_e rTypeOp(input int sel);
      case (sel)
         0:       return OP_ADD;
         1:       return OP_SUB;
         2:       return OP_AND;
         3:       return OP_OR;
         4:       return OP_XOR;
         default: return OP_SLT;
      endcase
   endfunction

   // R-type results as the ISA defines them, SLT is a signed compare
   function automatic dataWord_t aluModel(input opcode_e op, input dataWord_t a,
                                          input dataWord_t b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         default: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
      endcase
   endfunction

   task automatic fillMemories();
      for (int a = 0; a < 256; a++) begin
         imem[a] = {OP_HALT, 4'h0, 8'(a)};
         dmem[a] = {8'(a), ~8'(a)};
      end
      loadPtr = 0;
   endtask

   task automatic emit(input dataWord_t w);
      imem[loadPtr[7:0]] = w;
      loadPtr++;
   endtask

   // Runs the loaded program one instruction at a time, no pipeline
   task automatic runModel(output logic expErr);
      dataWord_t regs [8];
      dataWord_t mem [256];
      dataWord_t pc, a, b, imm, ea;
      instr_u    iw;
      opcode_e   op;
      regIdx_t   rd;
      logic      done;
      int        steps;
      expAddr.delete();
      expData.delete();
      for (int i = 0; i < 256; i++) begin
         mem[i] = dmem[i];
      end
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc     = RESET_PC;
      expErr = 1'b0;
      done   = 1'b0;
      steps  = 0;
      while (!done && steps < TEST_LIMIT) begin
         iw  = imem[pc[7:0]];
         op  = iw.r.opcode;
         rd  = iw.r.rd;
         a   = regs[iw.r.rs];
         b   = regs[iw.r.rt];
         imm = {{10{iw.i.imm[5]}}, iw.i.imm};
         ea  = a + imm;
         pc  = pc + 16'd1;
         steps++;
         case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: regs[rd] = aluModel(op, a, b);
            OP_ADDI: regs[rd] = ea;
            OP_LW:   regs[rd] = mem[ea[7:0]];
            OP_SW: begin
               expAddr.push_back(ea);
               expData.push_back(regs[rd]);
               mem[ea[7:0]] = regs[rd];
            end
            OP_BEQZ: if (regs[rd] == '0) pc = pc + imm;
            OP_NOP:  ;
            OP_HALT: done = 1'b1;
            default: begin
               expErr = 1'b1;
               done   = 1'b1;
            end
         endcase
         regs[0] = '0;
      end
   endtask

   task automatic resetDut();
      @(negedge clk);
      resetReq <= 1'b1;
      @(negedge clk);
      resetReq <= 1'b0;
      @(posedge rstN);
      gotAddr.delete();
      gotData.delete();
   endtask

   task automatic compareStores(input string name);
      int n;
      if (gotAddr.size() != expAddr.size()) begin
         $display("Test %s saw %0d stores where %0d were expected",
                  name, gotAddr.size(), expAddr.size());
         errorCount++;
      end
      n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
      for (int i = 0; i < n; i++) begin
         checkWord($sformatf("store %0d address", i), gotAddr[i], expAddr[i]);
         checkWord($sformatf("store %0d data", i), gotData[i], expData[i]);
      end
   endtask

   task automatic runTest(input string name);
      logic expErr;
      int   errsBefore;
      int   waited;
      errsBefore = errorCount;
      runModel(expErr);
      resetDut();
      waited = 0;
      while (!halted && waited < TEST_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!halted) begin
         $display("Test %s: halted did not rise within %0d cycles", name, TEST_LIMIT);
         errorCount++;
      end
      // A few more cycles so a stray store after the stop would show
      repeat (4) @(negedge clk);
      checkFlag("halted", halted, 1'b1);
      checkFlag("err", err, expErr);
      compareStores(name);
      testCount++;
      if (errorCount == errsBefore) begin
         $display("Test %s: pass", name);
      end else begin
         $display("Test %s: fail with %0d mismatches", name, errorCount - errsBefore);
      end
   endtask

   task automatic aluChainTest();
      fillMemories();
      emit(encodeI(OP_ADDI, 1, 0, 5));
      emit(encodeI(OP_ADDI, 2, 1, -3));
      emit(encodeR(OP_ADD, 3, 1, 2));
      emit(encodeR(OP_SUB, 4, 2, 3));
      emit(encodeR(OP_AND, 5, 4, 3));
      emit(encodeR(OP_OR, 6, 5, 4));
      emit(encodeR(OP_XOR, 7, 6, 1));
      emit(encodeR(OP_SLT, 1, 4, 2));
      emit(encodeI(OP_SW, 1, 0, 10));
      emit(encodeI(OP_SW, 3, 0, 11));
      emit(encodeI(OP_SW, 4, 0, 12));
      emit(encodeI(OP_SW, 5, 0, 13));
      emit(encodeI(OP_SW, 6, 0, 14));
      emit(encodeI(OP_SW, 7, 0, 15));
      emit(encodeR(OP_HALT, 0, 0, 0));
      runTest("aluChain");
   endtask

   task automatic loadAddTest();
      fillMemories();
      dmem[3] = 16'h1234;
      dmem[4] = 16'h0FF0;
      emit(encodeI(OP_ADDI, 1, 0, 3));
      emit(encodeI(OP_LW, 2, 1, 0));
      emit(encodeI(OP_LW, 3, 1, 1));
      emit(encodeR(OP_ADD, 4, 2, 3));
      emit(encodeI(OP_SW, 4, 1, 5));
      emit(encodeR(OP_HALT, 0, 0, 0));
      runTest("loadAdd");
   endtask

   // Not taken, taken forward, then a countdown loop with a backward branch
   task automatic branchTest();
      fillMemories();
      emit(encodeI(OP_ADDI, 1, 0, 2));
      emit(encodeI(OP_ADDI, 2, 0, 0));
      emit(encodeI(OP_BEQZ, 1, 0, 3));
      emit(encodeI(OP_SW, 1, 0, 20));
      emit(encodeI(OP_BEQZ, 2, 0, 2));
      emit(encodeI(OP_SW, 1, 0, 21));
      emit(encodeI(OP_SW, 2, 0, 22));
      emit(encodeI(OP_SW, 1, 0, 23));
      emit(encodeI(OP_ADDI, 1, 1, -1));
      emit(encodeI(OP_BEQZ, 1, 0, 1));
      emit(encodeI(OP_BEQZ, 0, 0, -4));
      emit(encodeR(OP_HALT, 0, 0, 0));
      emit(encodeI(OP_SW, 1, 0, 24));
      runTest("branch");
   endtask

   task automatic haltTest();
      fillMemories();
      emit(encodeI(OP_ADDI, 1, 0, 7));
      emit(encodeI(OP_SW, 1, 0, 1));
      emit(encodeR(OP_HALT, 0, 0, 0));
      emit(encodeI(OP_SW, 1, 0, 2));
      emit(encodeI(OP_SW, 1, 0, 3));
      runTest("halt");
   endtask

   task automatic illegalOpTest();
      fillMemories();
      emit(encodeI(OP_ADDI, 1, 0, 9));
      emit(encodeI(OP_SW, 1, 0, 4));
      // Opcode 4'hC has no instruction
      emit({4'hC, 12'h000});
      emit(encodeI(OP_SW, 1, 0, 5));
      runTest("illegalOp");
   endtask

   task automatic randomOpsTest();
      opcode_e op;
      fillMemories();
      for (int k = 0; k < 10; k++) begin
         dmem[2*k]     = dataWord_t'($urandom);
         dmem[2*k + 1] = dataWord_t'($urandom);
         op = rTypeOp($urandom_range(5, 0));
         emit(encodeI(OP_LW, 1, 0, 2*k));
         emit(encodeI(OP_LW, 2, 0, 2*k + 1));
         emit(encodeR(op, 3, 1, 2));
         emit(encodeI(OP_SW, 3, 0, 20 + k));
      end
      emit(encodeR(OP_HALT, 0, 0, 0));
      runTest("randomOps");
   endtask

   initial begin
      resetReq   = 1'b0;
      errorCount = 0;
      checkCount = 0;
      testCount  = 0;
      void'($urandom(95669));
      fillMemories();
      aluChainTest();
      loadAddTest();
      branchTest();
      haltTest();
      illegalOpTest();
      randomOpsTest();
      $display("Tests: %0d, checks: %0d, failures: %0d", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: verif/tbClock.sv
//********************
// Testbench clock and reset generator
//********************
`timescale 1ns/1ps

module tbClock #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 3
) (
   input  logic resetReq,
   output logic clk,
   output logic rstN
);

   int lowLeft;

   initial begin
      clk     = 1'b0;
      rstN    = 1'b0;
      lowLeft = RESET_CYCLES - 1;
   end

   always #HALF_PERIOD clk = ~clk;

   // Reset moves on the falling edge, a request restarts the low phase
   always @(negedge clk) begin
      if (resetReq) begin
         lowLeft = RESET_CYCLES;
      end
      if (lowLeft > 0) begin
         rstN   <= 1'b0;
         lowLeft = lowLeft - 1;
      end else begin
         rstN <= 1'b1;
      end
   end

endmodule

// File: src/pipeCpu.sv
//********************
// Five-stage 16-bit processor top level
//********************
`timescale 1ns/1ps

module pipeCpu import cpuPkg::*; #(
   parameter dataWord_t RESET_PC = '0
) (
   input  logic      clk,
   input  logic      rstN,
   output dataWord_t imemAddr,
   input  dataWord_t imemData,
   output dataWord_t dmemAddr,
   output dataWord_t dmemWrData,
   output logic      dmemWrEn,
   output logic      dmemRdEn,
   input  dataWord_t dmemRdData,
   output logic      halted,
   output logic      err
);

   instr_u    fdInstr;
   dataWord_t fdPc, redirectPc, wbData;
   logic      stall, freeze, redirect;
   logic      exWrt, memWrt, wbEn;
   regIdx_t   exDest, memDest, wbIdx;

   idExIf  idEx ();
   exMemIf exMem ();

   fetchStage #(.RESET_PC(RESET_PC)) u_fetch (
      .clk(clk), .rstN(rstN),
      .stall(stall), .freeze(freeze),
      .redirect(redirect), .redirectPc(redirectPc),
      .imemAddr(imemAddr), .imemData(imemData),
      .instr(fdInstr), .pc(fdPc)
   );

   decodeStage u_decode (
      .clk(clk), .rstN(rstN),
      .instr(fdInstr), .pc(fdPc), .flush(redirect),
      .exDest(exDest), .exWrt(exWrt), .memDest(memDest), .memWrt(memWrt),
      .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData),
      .stall(stall), .freeze(freeze), .err(err),
      .idEx(idEx.source)
   );

   executeStage u_execute (
      .clk(clk), .rstN(rstN),
      .idEx(idEx.sink),
      .redirect(redirect), .redirectPc(redirectPc),
      .exDest(exDest), .exWrt(exWrt),
      .exMem(exMem.source)
   );

   memoryStage u_memory (
      .clk(clk), .rstN(rstN),
      .exMem(exMem.sink),
      .dmemAddr(dmemAddr), .dmemWrData(dmemWrData),
      .dmemWrEn(dmemWrEn), .dmemRdEn(dmemRdEn), .dmemRdData(dmemRdData),
      .memDest(memDest), .memWrt(memWrt),
      .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData),
      .halted(halted)
   );

endmodule

// File: src/memoryStage.sv
//********************
// Memory stage with data memory drive
// and the write-back select
//********************
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   exMemIf.sink      exMem,
   output dataWord_t dmemAddr,
   output dataWord_t dmemWrData,
   output logic      dmemWrEn,
   output logic      dmemRdEn,
   input  dataWord_t dmemRdData,
   output regIdx_t   memDest,
   output logic      memWrt,
   output logic      wbEn,
   output regIdx_t   wbIdx,
   output dataWord_t wbData,
   output logic      halted
);

   logic      wbLoad;
   dataWord_t loadData;
   dataWord_t aluData;

   assign dmemAddr   = exMem.aluResult;
   assign dmemWrData = exMem.storeData;
   assign dmemWrEn   = exMem.valid && exMem.memWrite;
   assign dmemRdEn   = exMem.valid && exMem.memRead;

   assign memDest = exMem.dest;
   assign memWrt  = exMem.valid && exMem.regWrite;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbEn   <= memWrt;
         halted <= halted | (exMem.valid && exMem.halt);
      end
   end

   always_ff @(posedge clk) begin
      wbIdx    <= exMem.dest;
      wbLoad   <= exMem.memRead;
      loadData <= dmemRdData;
      aluData  <= exMem.aluResult;
   end

   // Write-back select
   assign wbData = wbLoad ? loadData : aluData;

   // Decode never sets both memory controls for one opcode
   oneMemAccess: assert property (@(posedge clk) disable iff (!rstN)
      !(dmemWrEn && dmemRdEn));

endmodule

// File: src/executeStage.sv
//********************
// Execute stage with the ALU, branch resolution
// and the execute-to-memory register
//********************
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   idExIf.sink       idEx,
   output logic      redirect,
   output dataWord_t redirectPc,
   output regIdx_t   exDest,
   output logic      exWrt,
   exMemIf.source    exMem
);

   dataWord_t aluOut;

   always_comb begin
      case (idEx.aluOp)
         ALU_ADD: aluOut = idEx.opA + idEx.opB;
         ALU_SUB: aluOut = idEx.opA - idEx.opB;
         ALU_AND: aluOut = idEx.opA & idEx.opB;
         ALU_OR:  aluOut = idEx.opA | idEx.opB;
         ALU_XOR: aluOut = idEx.opA ^ idEx.opB;
         ALU_SLT: aluOut = {15'd0, $signed(idEx.opA) < $signed(idEx.opB)};
         default: aluOut = '0;
      endcase
   end

   // BEQZ tests rd, which rides in the store data slot
   assign redirectPc = idEx.pc + 16'd1 + idEx.opB;
   assign redirect   = idEx.valid && idEx.branch && idEx.storeData == '0;

   // Hazard report for decode
   assign exDest = idEx.dest;
   assign exWrt  = idEx.valid && idEx.regWrite;

   // A taken branch leaves nothing for the memory stage
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exMem.valid    <= 1'b0;
         exMem.regWrite <= 1'b0;
         exMem.memRead  <= 1'b0;
         exMem.memWrite <= 1'b0;
         exMem.halt     <= 1'b0;
      end else begin
         exMem.valid    <= idEx.valid && !redirect;
         exMem.regWrite <= idEx.regWrite;
         exMem.memRead  <= idEx.memRead;
         exMem.memWrite <= idEx.memWrite;
         exMem.halt     <= idEx.halt;
      end
   end

   always_ff @(posedge clk) begin
      exMem.aluResult <= aluOut;
      exMem.storeData <= idEx.storeData;
      exMem.dest      <= idEx.dest;
   end

   // Decode flushes on redirect, so the next cycle holds a bubble
   redirectOnBranch: assert property (@(posedge clk) disable iff (!rstN)
      redirect |=> !idEx.valid);

endmodule

// File: src/decodeStage.sv
//********************
// Decode stage with hazard stall, illegal opcode
// trap and the decode-to-execute register
//********************
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   input  instr_u    instr,
   input  dataWord_t pc,
   input  logic      flush,
   input  regIdx_t   exDest,
   input  logic      exWrt,
   input  regIdx_t   memDest,
   input  logic      memWrt,
   input  logic      wbEn,
   input  regIdx_t   wbIdx,
   input  dataWord_t wbData,
   output logic      stall,
   output logic      freeze,
   output logic      err,
   idExIf.source     idEx
);

   opcode_e   opcode;
   logic      isRType;
   regIdx_t   bIdx;
   dataWord_t rsData;
   dataWord_t bData;
   dataWord_t immExt;
   aluOp_e    aluOp;
   logic      useImm, readRs, readB, regWrite;
   logic      memRead, memWrite, branch, halt, illegal;
   logic      haltSeen;

   assign opcode  = instr.r.opcode;
   assign isRType = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
   // Second read port gives rt for R-type, rd for SW and BEQZ
   assign bIdx    = isRType ? instr.r.rt : instr.r.rd;
   assign immExt  = {{10{instr.i.imm[5]}}, instr.i.imm};

   regFile u_regFile (
      .clk       (clk),
      .rstN      (rstN),
      .rdIdxA    (instr.r.rs),
      .rdIdxB    (bIdx),
      .rdDataA   (rsData),
      .rdDataB   (bData),
      .writeEn   (wbEn),
      .writeIdx  (wbIdx),
      .writeData (wbData)
   );

   always_comb begin
      aluOp    = ALU_ADD;
      useImm   = 1'b0;
      readRs   = isRType;
      readB    = isRType;
      regWrite = isRType;
      memRead  = 1'b0;
      memWrite = 1'b0;
      branch   = 1'b0;
      halt     = 1'b0;
      illegal  = 1'b0;
      case (opcode)
         OP_ADD:  aluOp = ALU_ADD;
         OP_SUB:  aluOp = ALU_SUB;
         OP_AND:  aluOp = ALU_AND;
         OP_OR:   aluOp = ALU_OR;
         OP_XOR:  aluOp = ALU_XOR;
         OP_SLT:  aluOp = ALU_SLT;
         OP_ADDI: begin
            useImm   = 1'b1;
            readRs   = 1'b1;
            regWrite = 1'b1;
         end
         OP_LW: begin
            useImm   = 1'b1;
            readRs   = 1'b1;
            regWrite = 1'b1;
            memRead  = 1'b1;
         end
         OP_SW: begin
            useImm   = 1'b1;
            readRs   = 1'b1;
            readB    = 1'b1;
            memWrite = 1'b1;
         end
         OP_BEQZ: begin
            useImm = 1'b1;
            readB  = 1'b1;
            branch = 1'b1;
         end
         OP_NOP:  ;
         OP_HALT: halt = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   // Source register still in flight in execute or memory
   function automatic logic inFlight(input regIdx_t idx);
      return idx != '0 && ((exWrt && exDest == idx) || (memWrt && memDest == idx));
   endfunction

   assign stall  = !flush && ((readRs && inFlight(instr.r.rs)) || (readB && inFlight(bIdx)));
   assign freeze = haltSeen || ((halt || illegal) && !flush);

   // Sticky halt and error flags
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         haltSeen <= 1'b0;
         err      <= 1'b0;
      end else if (!flush) begin
         haltSeen <= haltSeen | halt | illegal;
         err      <= err | illegal;
      end
   end

   // Control half of the register, bubble on stall or flush
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         idEx.valid    <= 1'b0;
         idEx.regWrite <= 1'b0;
         idEx.memRead  <= 1'b0;
         idEx.memWrite <= 1'b0;
         idEx.branch   <= 1'b0;
         idEx.halt     <= 1'b0;
      end else if (stall || flush) begin
         idEx.valid    <= 1'b0;
         idEx.regWrite <= 1'b0;
         idEx.memRead  <= 1'b0;
         idEx.memWrite <= 1'b0;
         idEx.branch   <= 1'b0;
         idEx.halt     <= 1'b0;
      end else begin
         idEx.valid    <= 1'b1;
         idEx.regWrite <= regWrite && instr.r.rd != '0;
         idEx.memRead  <= memRead;
         idEx.memWrite <= memWrite;
         idEx.branch   <= branch;
         idEx.halt     <= halt || illegal;
      end
   end

   always_ff @(posedge clk) begin
      idEx.pc        <= pc;
      idEx.aluOp     <= aluOp;
      idEx.opA       <= rsData;
      idEx.opB       <= useImm ? immExt : bData;
      idEx.storeData <= bData;
      idEx.dest      <= instr.r.rd;
   end

endmodule

// File: src/regFile.sv
//********************
// Eight-entry register file, r0 reads zero
//********************
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   input  regIdx_t   rdIdxA,
   input  regIdx_t   rdIdxB,
   output dataWord_t rdDataA,
   output dataWord_t rdDataB,
   input  logic      writeEn,
   input  regIdx_t   writeIdx,
   input  dataWord_t writeData
);

   dataWord_t regs [8];

   // Same-cycle write is seen by the read
   assign rdDataA = (rdIdxA == '0) ? '0 :
                    (writeEn && writeIdx == rdIdxA) ? writeData : regs[rdIdxA];
   assign rdDataB = (rdIdxB == '0) ? '0 :
                    (writeEn && writeIdx == rdIdxB) ? writeData : regs[rdIdxB];

   always_ff @(posedge clk) begin
      if (writeEn) begin
         regs[writeIdx] <= writeData;
      end
   end

   // Decode never marks r0 as a destination
   noWriteR0: assert property (@(posedge clk) disable iff (!rstN)
      writeEn |-> writeIdx != '0);

endmodule

// File: src/fetchStage.sv
//********************
// Fetch stage with the PC and the
// fetch-to-decode register
//********************
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; #(
   parameter dataWord_t RESET_PC = '0
) (
   input  logic      clk,
   input  logic      rstN,
   input  logic      stall,
   input  logic      freeze,
   input  logic      redirect,
   input  dataWord_t redirectPc,
   output dataWord_t imemAddr,
   input  dataWord_t imemData,
   output instr_u    instr,
   output dataWord_t pc
);

   dataWord_t pcReg;

   assign imemAddr = pcReg;

   // Redirect wins over stall, stall wins over freeze
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pcReg <= RESET_PC;
         instr <= NOP_WORD;
      end else if (redirect) begin
         pcReg <= redirectPc;
         instr <= NOP_WORD;
      end else if (!stall) begin
         if (freeze) begin
            instr <= NOP_WORD;
         end else begin
            instr <= imemData;
            pcReg <= pcReg + 16'd1;
         end
      end
   end

   // PC of the instruction now in decode
   always_ff @(posedge clk) begin
      if (!redirect && !stall && !freeze) begin
         pc <= pcReg;
      end
   end

   // A hazard stall ends once the producer reaches write-back
   stallBounded: assert property (@(posedge clk) disable iff (!rstN)
      stall && $past(stall) |=> !stall);

endmodule

// File: src/stageIf.sv
//********************
// Signal bundles between the decode, execute
// and memory stages
//********************
`timescale 1ns/1ps

interface idExIf import cpuPkg::*; ();
   logic      valid;
   dataWord_t pc;
   aluOp_e    aluOp;
   dataWord_t opA;
   dataWord_t opB;
   dataWord_t storeData;
   regIdx_t   dest;
   logic      regWrite;
   logic      memRead;
   logic      memWrite;
   logic      branch;
   logic      halt;

   modport source (output valid, pc, aluOp, opA, opB, storeData, dest,
                   regWrite, memRead, memWrite, branch, halt);
   modport sink   (input valid, pc, aluOp, opA, opB, storeData, dest,
                   regWrite, memRead, memWrite, branch, halt);
endinterface

interface exMemIf import cpuPkg::*; ();
   logic      valid;
   dataWord_t aluResult;
   dataWord_t storeData;
   regIdx_t   dest;
   logic      regWrite;
   logic      memRead;
   logic      memWrite;
   logic      halt;

   modport source (output valid, aluResult, storeData, dest,
                   regWrite, memRead, memWrite, halt);
   modport sink   (input valid, aluResult, storeData, dest,
                   regWrite, memRead, memWrite, halt);
endinterface

// File: src/cpuPkg.sv
//********************
// Shared types, opcodes and instruction formats
// for the 16-bit pipelined processor
//********************
package cpuPkg;

   typedef logic [15:0] dataWord_t;
   typedef logic [2:0]  regIdx_t;

   // Codes 4'hB to 4'hE are illegal
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_OR   = 4'h4,
      OP_XOR  = 4'h5,
      OP_SLT  = 4'h6,
      OP_ADDI = 4'h7,
      OP_LW   = 4'h8,
      OP_SW   = 4'h9,
      OP_BEQZ = 4'hA,
      OP_HALT = 4'hF
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5
   } aluOp_e;

   // Register-register layout
   typedef struct packed {
      opcode_e    opcode;
      regIdx_t    rd;
      regIdx_t    rs;
      regIdx_t    rt;
      logic [2:0] spare;
   } rFmt_t;

   // Register-immediate layout, imm is signed
   typedef struct packed {
      opcode_e           opcode;
      regIdx_t           rd;
      regIdx_t           rs;
      logic signed [5:0] imm;
   } iFmt_t;

   typedef union packed {
      rFmt_t r;
      iFmt_t i;
   } instr_u;

   localparam logic [15:0] NOP_WORD = {OP_NOP, 12'h000};

endpackage
